/* Makefile */
# Verilator build for the max-pooling engine testbench

VERILATOR ?= verilator
TOP       ?= tb_pool
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* pool_cfg.sv */
// ==================================================
// Configuration register
// Captures the configuration word, decodes the job
// fields and raises start when the strobe falls
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_cfg (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_vld,
    input  logic [pool_pkg::cfg_width-1:0] cfg_info,
    input  logic                           cfg_rdy,
    output logic                           start,
    output logic [pool_pkg::idx_width-1:0] nip,
    output logic [pool_pkg::k_width-1:0]   k,
    output logic [pool_pkg::grp_width-1:0] num_grp,
    output logic [pool_pkg::idx_width-1:0] map_base,
    output logic [pool_pkg::idx_width-1:0] feat_base,
    output logic [pool_pkg::idx_width-1:0] wr_base
);
    import pool_pkg::*;

    logic [cfg_width-1:0] cfg_word;
    logic                 cfg_vld_d;
    logic                 stop;

    // Capture while the engine is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_word <= '0;
        end else if (cfg_vld && cfg_rdy) begin
            cfg_word <= cfg_info;
        end
    end

    // Strobe history, only strobes seen while idle count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_vld_d <= 1'b0;
        end else begin
            cfg_vld_d <= cfg_vld & cfg_rdy;
        end
    end

    assign stop = cfg_word[cfg_stop_pos];

    // Falling edge of the strobe launches the job
    assign start = cfg_vld_d & ~cfg_vld & ~stop;

    // ==================================================
    // Field decode
    // ==================================================
    assign nip       = cfg_word[cfg_nip_lsb +: idx_width];
    assign k         = cfg_word[cfg_k_lsb +: k_width];
    assign num_grp   = cfg_word[cfg_grp_lsb +: grp_width];
    assign map_base  = cfg_word[cfg_map_lsb +: idx_width];
    assign feat_base = cfg_word[cfg_feat_lsb +: idx_width];
    assign wr_base   = cfg_word[cfg_wr_lsb +: idx_width];

endmodule

`default_nettype wire

/* pool_gather.sv */
// ==================================================
// Feature gather
// Walks channel groups and neighbors of the buffered
// point and issues one feature read per step
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_gather (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [pool_pkg::k_width-1:0]   k,
    input  logic [pool_pkg::grp_width-1:0] num_grp,
    input  logic [pool_pkg::idx_width-1:0] feat_base,
    input  logic                           buf_full,
    output logic                           buf_release,
    output logic [pool_pkg::k_width-1:0]   nbr_rd_sel,
    input  logic [pool_pkg::idx_width-1:0] nbr_idx,
    output logic [pool_pkg::idx_width-1:0] feat_addr,
    output logic                           feat_addr_vld,
    input  logic                           feat_addr_rdy
);
    import pool_pkg::*;

    logic [k_width-1:0]   nbr_cnt;
    logic [grp_width-1:0] grp_cnt;
    logic                 addr_hs;
    logic                 last_nbr;
    logic                 last_grp;

    // Issue straight away once the buffer holds a point
    assign feat_addr_vld = buf_full;
    assign addr_hs       = feat_addr_vld & feat_addr_rdy;

    assign last_nbr = nbr_cnt == k - k_width'(1);
    assign last_grp = grp_cnt == num_grp - grp_width'(1);

    // Buffer is free once the final read is accepted
    assign buf_release = addr_hs & last_nbr & last_grp;

    // ==================================================
    // Step counters, neighbors inside groups
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nbr_cnt <= '0;
            grp_cnt <= '0;
        end else if (addr_hs) begin
            if (last_nbr) begin
                nbr_cnt <= '0;
                if (last_grp) begin
                    grp_cnt <= '0;
                end else begin
                    grp_cnt <= grp_cnt + grp_width'(1);
                end
            end else begin
                nbr_cnt <= nbr_cnt + k_width'(1);
            end
        end
    end

    assign nbr_rd_sel = nbr_cnt;

    // Feature rows are num_grp words per point
    assign feat_addr = feat_base + nbr_idx * idx_width'(num_grp) + idx_width'(grp_cnt);

endmodule

`default_nettype wire

/* pool_map_fetch.sv */
// ==================================================
// Map fetch and job control
// Job FSM, neighbor index reads from the map memory
// and the one-point neighbor buffer
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_map_fetch (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [pool_pkg::idx_width-1:0] nip,
    input  logic [pool_pkg::k_width-1:0]   k,
    input  logic [pool_pkg::idx_width-1:0] map_base,
    output logic [pool_pkg::idx_width-1:0] map_addr,
    output logic                           map_addr_vld,
    input  logic                           map_addr_rdy,
    input  logic [pool_pkg::idx_width-1:0] map_dat,
    input  logic                           map_dat_vld,
    output logic                           map_dat_rdy,
    output logic                           cfg_rdy,
    output logic                           buf_full,
    input  logic                           buf_release,
    input  logic [pool_pkg::k_width-1:0]   nbr_rd_sel,
    output logic [pool_pkg::idx_width-1:0] nbr_idx,
    input  logic                           job_done
);
    import pool_pkg::*;

    pool_state_e          state;
    pool_state_e          state_nxt;
    logic [idx_width-1:0] pt_cnt;
    logic [k_width-1:0]   word_cnt;
    logic [k_width-1:0]   rcv_cnt;
    logic                 addr_hs;
    logic                 dat_hs;
    logic                 last_dat;
    logic                 last_pt;
    logic [idx_width-1:0] nbr_buf [max_k];

    assign addr_hs  = map_addr_vld & map_addr_rdy;
    assign dat_hs   = map_dat_vld & map_dat_rdy;
    assign last_dat = dat_hs & (rcv_cnt == k - k_width'(1));
    assign last_pt  = pt_cnt == nip - idx_width'(1);

    // ==================================================
    // Job FSM
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            idle:
                if (start)
                    state_nxt = map_in;
            map_in:
                if (last_dat)
                    state_nxt = gather;
            gather:
                if (buf_release)
                    state_nxt = last_pt ? drain : map_in;
            drain:
                if (job_done)
                    state_nxt = idle;
            default:
                state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            pt_cnt   <= '0;
            word_cnt <= '0;
            rcv_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (start && state == idle) begin
                pt_cnt <= '0;
            end else if (buf_release && state == gather && !last_pt) begin
                pt_cnt <= pt_cnt + idx_width'(1);
            end
            // Issue and return counters restart per point
            if (last_dat) begin
                word_cnt <= '0;
                rcv_cnt  <= '0;
            end else begin
                if (addr_hs) begin
                    word_cnt <= word_cnt + k_width'(1);
                end
                if (dat_hs) begin
                    rcv_cnt <= rcv_cnt + k_width'(1);
                end
            end
        end
    end

    // Row of max_k words per center point
    assign map_addr     = map_base + (pt_cnt << max_k_log2) + idx_width'(word_cnt);
    assign map_addr_vld = (state == map_in) && (word_cnt != k);
    assign map_dat_rdy  = state == map_in;
    assign cfg_rdy      = state == idle;
    assign buf_full     = state == gather;

    // Neighbor buffer
    always_ff @(posedge clk) begin
        if (dat_hs) begin
            nbr_buf[rcv_cnt[max_k_log2-1:0]] <= map_dat;
        end
    end

    assign nbr_idx = nbr_buf[nbr_rd_sel[max_k_log2-1:0]];

endmodule

`default_nettype wire

/* pool_max_unit.sv */
// ==================================================
// Lane-wise max and result write
// Folds k feature beats into an unsigned per-lane
// maximum and writes one word per point and group
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_max_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [pool_pkg::idx_width-1:0]  nip,
    input  logic [pool_pkg::k_width-1:0]    k,
    input  logic [pool_pkg::grp_width-1:0]  num_grp,
    input  logic [pool_pkg::idx_width-1:0]  wr_base,
    input  logic [pool_pkg::feat_width-1:0] feat_dat,
    input  logic                            feat_dat_vld,
    output logic                            feat_dat_rdy,
    output logic [pool_pkg::idx_width-1:0]  wr_addr,
    output logic [pool_pkg::feat_width-1:0] wr_dat,
    output logic                            wr_vld,
    input  logic                            wr_rdy,
    output logic                            job_done
);
    import pool_pkg::*;

    logic [k_width-1:0]                   beat_cnt;
    logic [idx_width-1:0]                 wr_cnt;
    logic [idx_width-1:0]                 last_wr;
    logic [pool_lanes-1:0][act_width-1:0] max_reg;
    logic                                 dat_hs;
    logic                                 wr_hs;
    logic                                 first_beat;
    logic                                 last_beat;

    // Hold off new beats while a result waits
    assign feat_dat_rdy = ~(wr_vld & ~wr_rdy);
    assign dat_hs       = feat_dat_vld & feat_dat_rdy;
    assign wr_hs        = wr_vld & wr_rdy;
    assign first_beat   = beat_cnt == '0;
    assign last_beat    = beat_cnt == k - k_width'(1);
    assign last_wr      = nip * idx_width'(num_grp) - idx_width'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            wr_cnt   <= '0;
            wr_vld   <= 1'b0;
        end else if (start) begin
            beat_cnt <= '0;
            wr_cnt   <= '0;
            wr_vld   <= 1'b0;
        end else begin
            if (dat_hs) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + k_width'(1);
            end
            if (dat_hs && last_beat) begin
                wr_vld <= 1'b1;
            end else if (wr_rdy) begin
                wr_vld <= 1'b0;
            end
            if (wr_hs) begin
                wr_cnt <= wr_cnt + idx_width'(1);
            end
        end
    end

    // ==================================================
    // Per-lane max, first beat of a group loads
    // ==================================================
    always_ff @(posedge clk) begin
        if (dat_hs) begin
            for (int l = 0; l < pool_lanes; l++) begin
                if (first_beat || feat_dat[l*act_width +: act_width] > max_reg[l]) begin
                    max_reg[l] <= feat_dat[l*act_width +: act_width];
                end
            end
        end
    end

    // Results land in point-then-group order
    assign wr_addr  = wr_base + wr_cnt;
    assign wr_dat   = max_reg;
    assign job_done = wr_hs & (wr_cnt == last_wr);

endmodule

`default_nettype wire

/* pool_pkg.sv */
// ==================================================
// Max-pooling engine shared definitions
// Datapath widths, configuration word layout and
// the job state encoding
// ==================================================
`default_nettype none

package pool_pkg;

    // Datapath widths
    localparam int act_width  = 8;
    localparam int pool_lanes = 8;
    localparam int feat_width = pool_lanes * act_width;
    localparam int idx_width  = 16;

    // Neighbor buffer depth, also the map row stride
    localparam int max_k      = 8;
    localparam int max_k_log2 = $clog2(max_k);
    localparam int k_width    = 4;
    localparam int grp_width  = 4;

    // ==================================================
    // Configuration word fields, from bit 0 upward
    // ==================================================
    localparam int cfg_stop_pos = 0;
    localparam int cfg_nip_lsb  = cfg_stop_pos + 1;
    localparam int cfg_k_lsb    = cfg_nip_lsb + idx_width;
    localparam int cfg_grp_lsb  = cfg_k_lsb + k_width;
    localparam int cfg_map_lsb  = cfg_grp_lsb + grp_width;
    localparam int cfg_feat_lsb = cfg_map_lsb + idx_width;
    localparam int cfg_wr_lsb   = cfg_feat_lsb + idx_width;
    localparam int cfg_width    = cfg_wr_lsb + idx_width;

    // Job states
    typedef enum logic [1:0] {
        idle   = 2'd0,
        map_in = 2'd1,
        gather = 2'd2,
        drain  = 2'd3
    } pool_state_e;

endpackage

`default_nettype wire

/* pool_props.sv */
// ==================================================
// Handshake assertions for the pooling engine
// Bound into the top level
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_props (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            cfg_rdy,
    input logic [pool_pkg::idx_width-1:0]  map_addr,
    input logic                            map_addr_vld,
    input logic                            map_addr_rdy,
    input logic [pool_pkg::idx_width-1:0]  wr_addr,
    input logic [pool_pkg::feat_width-1:0] wr_dat,
    input logic                            wr_vld,
    input logic                            wr_rdy,
    input pool_pkg::pool_state_e           state
);
    import pool_pkg::*;

    // Result held while the memory stalls
    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && !wr_rdy |=> wr_vld && $stable(wr_addr) && $stable(wr_dat))
        else $error("result write changed while wr_rdy was low");

    // Map request held until accepted
    map_hold: assert property (@(posedge clk) disable iff (!rst_n)
        map_addr_vld && !map_addr_rdy |=> map_addr_vld && $stable(map_addr))
        else $error("map request dropped before map_addr_rdy");

    rdy_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> cfg_rdy)
        else $error("cfg_rdy low after reset");

    // No result left pending once the job has ended
    idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        state == idle |-> !wr_vld)
        else $error("result write pending while the engine is idle");

endmodule

bind pool_top pool_props pool_props_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_rdy      (cfg_rdy),
    .map_addr     (map_addr),
    .map_addr_vld (map_addr_vld),
    .map_addr_rdy (map_addr_rdy),
    .wr_addr      (wr_addr),
    .wr_dat       (wr_dat),
    .wr_vld       (wr_vld),
    .wr_rdy       (wr_rdy),
    .state        (pool_map_fetch_inst.state)
);

`default_nettype wire

/* pool_top.sv */
// ==================================================
// Max-pooling engine top level
// Configuration, map fetch, gather and max blocks
// wired to the memory ports
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pool_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Configuration
    input  logic                            cfg_vld,
    input  logic [pool_pkg::cfg_width-1:0]  cfg_info,
    output logic                            cfg_rdy,
    // Map memory
    output logic [pool_pkg::idx_width-1:0]  map_addr,
    output logic                            map_addr_vld,
    input  logic                            map_addr_rdy,
    input  logic [pool_pkg::idx_width-1:0]  map_dat,
    input  logic                            map_dat_vld,
    output logic                            map_dat_rdy,
    // Feature memory
    output logic [pool_pkg::idx_width-1:0]  feat_addr,
    output logic                            feat_addr_vld,
    input  logic                            feat_addr_rdy,
    input  logic [pool_pkg::feat_width-1:0] feat_dat,
    input  logic                            feat_dat_vld,
    output logic                            feat_dat_rdy,
    // Result write
    output logic [pool_pkg::idx_width-1:0]  wr_addr,
    output logic [pool_pkg::feat_width-1:0] wr_dat,
    output logic                            wr_vld,
    input  logic                            wr_rdy
);
    import pool_pkg::*;

    logic                 start;
    logic [idx_width-1:0] nip;
    logic [k_width-1:0]   k;
    logic [grp_width-1:0] num_grp;
    logic [idx_width-1:0] map_base;
    logic [idx_width-1:0] feat_base;
    logic [idx_width-1:0] wr_base;
    logic                 buf_full;
    logic                 buf_release;
    logic [k_width-1:0]   nbr_rd_sel;
    logic [idx_width-1:0] nbr_idx;
    logic                 job_done;

    pool_cfg pool_cfg_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_vld   (cfg_vld),
        .cfg_info  (cfg_info),
        .cfg_rdy   (cfg_rdy),
        .start     (start),
        .nip       (nip),
        .k         (k),
        .num_grp   (num_grp),
        .map_base  (map_base),
        .feat_base (feat_base),
        .wr_base   (wr_base)
    );

    pool_map_fetch pool_map_fetch_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .nip          (nip),
        .k            (k),
        .map_base     (map_base),
        .map_addr     (map_addr),
        .map_addr_vld (map_addr_vld),
        .map_addr_rdy (map_addr_rdy),
        .map_dat      (map_dat),
        .map_dat_vld  (map_dat_vld),
        .map_dat_rdy  (map_dat_rdy),
        .cfg_rdy      (cfg_rdy),
        .buf_full     (buf_full),
        .buf_release  (buf_release),
        .nbr_rd_sel   (nbr_rd_sel),
        .nbr_idx      (nbr_idx),
        .job_done     (job_done)
    );

    pool_gather pool_gather_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .k             (k),
        .num_grp       (num_grp),
        .feat_base     (feat_base),
        .buf_full      (buf_full),
        .buf_release   (buf_release),
        .nbr_rd_sel    (nbr_rd_sel),
        .nbr_idx       (nbr_idx),
        .feat_addr     (feat_addr),
        .feat_addr_vld (feat_addr_vld),
        .feat_addr_rdy (feat_addr_rdy)
    );

    pool_max_unit pool_max_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .nip          (nip),
        .k            (k),
        .num_grp      (num_grp),
        .wr_base      (wr_base),
        .feat_dat     (feat_dat),
        .feat_dat_vld (feat_dat_vld),
        .feat_dat_rdy (feat_dat_rdy),
        .wr_addr      (wr_addr),
        .wr_dat       (wr_dat),
        .wr_vld       (wr_vld),
        .wr_rdy       (wr_rdy),
        .job_done     (job_done)
    );

endmodule

`default_nettype wire

/* tb_pool.sv */
// ==================================================
// Max-pooling engine testbench
// Map, feature and write memory models, reference
// max-pool model and result checker
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_pool;
    import pool_pkg::*;

    localparam int mem_depth = 1024;

    logic                 clk;
    logic                 rst_n;
    logic                 cfg_vld;
    logic [cfg_width-1:0] cfg_info;
    logic                 cfg_rdy;
    logic [idx_width-1:0] map_addr;
    logic                 map_addr_vld;
    logic                 map_addr_rdy;
    logic [idx_width-1:0] map_dat;
    logic                 map_dat_vld;
    logic                 map_dat_rdy;
    logic [idx_width-1:0] feat_addr;
    logic                 feat_addr_vld;
    logic                 feat_addr_rdy;
    logic [feat_width-1:0] feat_dat;
    logic                 feat_dat_vld;
    logic                 feat_dat_rdy;
    logic [idx_width-1:0] wr_addr;
    logic [feat_width-1:0] wr_dat;
    logic                 wr_vld;
    logic                 wr_rdy;

    logic [idx_width-1:0]  map_mem [mem_depth];
    logic [feat_width-1:0] feat_mem [mem_depth];
    logic [idx_width-1:0]  map_aq[$];
    int                    map_due[$];
    logic [idx_width-1:0]  feat_aq[$];
    int                    feat_due[$];

    integer seed;
    int     cyc;
    int     stall_pct;
    string  test_name;
    int     job_nip;
    int     job_k;
    int     job_ng;
    int     job_map_base;
    int     job_feat_base;
    int     job_wr_base;
    int     wr_cnt;
    int     test_err;
    int     err_total;
    int     tests_run;
    int     tests_failed;
    logic [idx_width-1:0]  exp_addr;
    logic [feat_width-1:0] exp_dat;

    pool_top pool_top_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    function automatic logic [cfg_width-1:0] build_cfg(input bit stop, input int nip,
        input int kk, input int ng, input int mbase, input int fbase, input int wbase);
        logic [cfg_width-1:0] w;
        w = '0;
        w[cfg_stop_pos]                 = stop;
        w[cfg_nip_lsb +: idx_width]     = idx_width'(nip);
        w[cfg_k_lsb +: k_width]         = k_width'(kk);
        w[cfg_grp_lsb +: grp_width]     = grp_width'(ng);
        w[cfg_map_lsb +: idx_width]     = idx_width'(mbase);
        w[cfg_feat_lsb +: idx_width]    = idx_width'(fbase);
        w[cfg_wr_lsb +: idx_width]      = idx_width'(wbase);
        return w;
    endfunction

    // Expected max over the k neighbors of one point and group
    function automatic logic [feat_width-1:0] pool_ref(input int pt, input int grp);
        logic [feat_width-1:0] res;
        logic [feat_width-1:0] w;
        int                    idx;
        res = '0;
        for (int n = 0; n < job_k; n++) begin
            idx = int'(map_mem[(job_map_base + pt * max_k + n) % mem_depth]);
            w   = feat_mem[(job_feat_base + idx * job_ng + grp) % mem_depth];
            for (int l = 0; l < pool_lanes; l++) begin
                if (n == 0 || w[l*act_width +: act_width] > res[l*act_width +: act_width])
                    res[l*act_width +: act_width] = w[l*act_width +: act_width];
            end
        end
        return res;
    endfunction

    task automatic note_error();
        test_err++;
        err_total++;
    endtask

    // ==================================================
    // Memory models
    // ==================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            map_addr_rdy <= 1'b0;
            map_dat_vld  <= 1'b0;
            map_dat      <= '0;
        end else begin
            if (map_dat_vld && map_dat_rdy) begin
                void'(map_aq.pop_front());
                void'(map_due.pop_front());
            end
            if (map_addr_vld && map_addr_rdy) begin
                map_aq.push_back(map_addr);
                map_due.push_back(cyc + rand_range(1, 3));
            end
            // Oldest request goes out once its delay has passed
            if (map_aq.size() > 0 && map_due[0] <= cyc) begin
                map_dat_vld <= 1'b1;
                map_dat     <= map_mem[map_aq[0] % mem_depth];
            end else begin
                map_dat_vld <= 1'b0;
            end
            map_addr_rdy <= rand_range(0, 99) >= stall_pct;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            feat_addr_rdy <= 1'b0;
            feat_dat_vld  <= 1'b0;
            feat_dat      <= '0;
        end else begin
            if (feat_dat_vld && feat_dat_rdy) begin
                void'(feat_aq.pop_front());
                void'(feat_due.pop_front());
            end
            if (feat_addr_vld && feat_addr_rdy) begin
                feat_aq.push_back(feat_addr);
                feat_due.push_back(cyc + rand_range(1, 3));
            end
            if (feat_aq.size() > 0 && feat_due[0] <= cyc) begin
                feat_dat_vld <= 1'b1;
                feat_dat     <= feat_mem[feat_aq[0] % mem_depth];
            end else begin
                feat_dat_vld <= 1'b0;
            end
            feat_addr_rdy <= rand_range(0, 99) >= stall_pct;
        end
    end

    always @(posedge clk) begin
        if (!rst_n)
            wr_rdy <= 1'b0;
        else
            wr_rdy <= rand_range(0, 99) >= stall_pct;
    end

    // ==================================================
    // Result checker
    // ==================================================
    always @(posedge clk) begin
        if (rst_n && wr_vld && wr_rdy) begin
            assert (wr_cnt < job_nip * job_ng) else begin
                $display("Unexpected write to address %h in test %s", wr_addr, test_name);
                note_error();
            end
            if (wr_cnt < job_nip * job_ng) begin
                exp_addr = idx_width'(job_wr_base + wr_cnt);
                exp_dat  = pool_ref(wr_cnt / job_ng, wr_cnt % job_ng);
                assert (wr_addr == exp_addr) else begin
                    $display("[FAIL] %s address: expected %h, actual %h",
                             test_name, exp_addr, wr_addr);
                    note_error();
                end
                assert (wr_dat == exp_dat) else begin
                    $display("[FAIL] %s data at %h: expected %h, actual %h",
                             test_name, exp_addr, exp_dat, wr_dat);
                    note_error();
                end
            end
            wr_cnt++;
        end
    end

    task automatic wait_cfg_rdy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (cfg_rdy !== level && n < limit);
        if (cfg_rdy !== level) begin
            $display("Timeout waiting for %s in test %s", what, test_name);
            $display("Testbench failed");
            $finish;
        end
    endtask

    task automatic send_cfg(input logic [cfg_width-1:0] word);
        wait_cfg_rdy(1'b1, 100, "configuration ready");
        cfg_info <= word;
        cfg_vld  <= 1'b1;
        @(posedge clk);
        cfg_vld  <= 1'b0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_err > 0)
            tests_failed++;
        $display("%s: %0d writes, %0d errors", test_name, wr_cnt, test_err);
    endtask

    task automatic run_job(input string name, input int nip, input int kk, input int ng,
        input int mbase, input int fbase, input int wbase, input int stall, input bit refill);
        int total;
        total         = nip * ng;
        test_name     = name;
        job_nip       = nip;
        job_k         = kk;
        job_ng        = ng;
        job_map_base  = mbase;
        job_feat_base = fbase;
        job_wr_base   = wbase;
        stall_pct     = stall;
        test_err      = 0;
        wr_cnt        = 0;
        // One map row of max_k indices per center point
        if (refill) begin
            for (int a = 0; a < nip * max_k; a++)
                map_mem[mbase + a] = idx_width'(rand_range(0, 63));
        end
        send_cfg(build_cfg(1'b0, nip, kk, ng, mbase, fbase, wbase));
        wait_cfg_rdy(1'b0, 20, "job start");
        wait_cfg_rdy(1'b1, 20000, "job end");
        assert (wr_cnt == total) else begin
            $display("[FAIL] %s write count: expected %0d, actual %0d", name, total, wr_cnt);
            note_error();
        end
        finish_test();
    endtask

    initial begin
        int nip_r;
        int k_r;
        int ng_r;
        seed         = 18;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cfg_vld      = 1'b0;
        cfg_info     = '0;
        map_addr_rdy = 1'b0;
        map_dat      = '0;
        map_dat_vld  = 1'b0;
        feat_addr_rdy = 1'b0;
        feat_dat     = '0;
        feat_dat_vld = 1'b0;
        wr_rdy       = 1'b0;
        cyc          = 0;
        stall_pct    = 0;
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int a = 0; a < mem_depth; a++) begin
            map_mem[a]  = '0;
            feat_mem[a] = {$random(seed), $random(seed)};
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        run_job("k1_copy", 6, 1, 1, 16, 32, 100, 0, 1'b1);
        nip_r = rand_range(4, 10);
        k_r   = rand_range(1, max_k);
        ng_r  = rand_range(1, 4);
        run_job("random_job", nip_r, k_r, ng_r, 64, 128, 200, 0, 1'b1);
        run_job("random_stall", nip_r, k_r, ng_r, 64, 128, 200, 40, 1'b0);

        // Stop bit set, the engine must stay idle
        test_name = "stop_bit";
        job_nip   = 0;
        job_ng    = 1;
        test_err  = 0;
        wr_cnt    = 0;
        stall_pct = 0;
        send_cfg(build_cfg(1'b1, 4, 2, 1, 64, 128, 300));
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            assert (cfg_rdy) else begin
                $display("cfg_rdy went low after a configuration with the stop bit set");
                note_error();
            end
        end
        finish_test();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
pool_pkg.sv
pool_cfg.sv
pool_map_fetch.sv
pool_gather.sv
pool_max_unit.sv
pool_top.sv
pool_props.sv
tb_pool.sv
